// File: verilog/core_cfg_pkg.sv
`default_nettype none

package core_cfg_pkg;

  localparam int XLEN   = 32;
  localparam int NREGS  = 16; // RV32E
  localparam int REG_AW = 4;

endpackage

`default_nettype wire

// File: verilog/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  ////////////////////////////////////////////////////////////
  // Major opcodes handled by the decode slice
  ////////////////////////////////////////////////////////////
  typedef enum logic [6:0] {
    OP_LUI   = 7'b0110111,
    OP_AUIPC = 7'b0010111,
    OP_OP    = 7'b0110011, // R-type
    OP_OPIMM = 7'b0010011  // I-type
  } opcode_e;

  ////////////////////////////////////////////////////////////
  // ALU operations
  ////////////////////////////////////////////////////////////
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS2 // Result is op2, used by LUI
  } alu_op_e;

  // Instruction field positions
  localparam int RD_LSB     = 7;
  localparam int FUNCT3_LSB = 12;
  localparam int RS1_LSB    = 15;
  localparam int RS2_LSB    = 20;
  localparam int ALT_BIT    = 30; // funct7 bit selecting SUB and SRA

endpackage

`default_nettype wire

// File: verilog/reg_file.sv
`default_nettype none

module reg_file (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [core_cfg_pkg::REG_AW-1:0]   raddr1_i,
  input  logic [core_cfg_pkg::REG_AW-1:0]   raddr2_i,
  output logic [core_cfg_pkg::XLEN-1:0]     rdata1_o,
  output logic [core_cfg_pkg::XLEN-1:0]     rdata2_o,
  input  logic                              we_i,
  input  logic [core_cfg_pkg::REG_AW-1:0]   waddr_i,
  input  logic [core_cfg_pkg::XLEN-1:0]     wdata_i,
  input  logic                              set_busy_i,
  input  logic [core_cfg_pkg::REG_AW-1:0]   set_addr_i,
  output logic [core_cfg_pkg::NREGS-1:0]    busy_o
);

  logic [core_cfg_pkg::XLEN-1:0] regs [core_cfg_pkg::NREGS];

  always_ff @(posedge clk) begin
    if (we_i && waddr_i != '0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // x0 reads as zero whatever the array holds
  assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

  ////////////////////////////////////////////////////////////
  // Busy scoreboard
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      busy_o <= '0;
    end else begin
      if (we_i) begin
        busy_o[waddr_i] <= 1'b0; // Retire clears
      end
      // Issue on the same edge wins over the retire
      if (set_busy_i && set_addr_i != '0) begin
        busy_o[set_addr_i] <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/idu_decoder.sv
`default_nettype none

module idu_decoder (
  input  logic [31:0]                         inst_i,
  input  logic [core_cfg_pkg::XLEN-1:0]       pc_i,
  input  logic [core_cfg_pkg::XLEN-1:0]       rs1v_i,
  input  logic [core_cfg_pkg::XLEN-1:0]       rs2v_i,
  output logic [core_cfg_pkg::XLEN-1:0]       op1_o,
  output logic [core_cfg_pkg::XLEN-1:0]       op2_o,
  output rv_isa_pkg::alu_op_e                 alu_op_o,
  output logic [core_cfg_pkg::REG_AW-1:0]     rd_o,
  output logic                                wen_o,
  output logic                                use_rs1_o,
  output logic                                use_rs2_o,
  output logic                                illegal_o
);

  rv_isa_pkg::opcode_e           opcode;
  logic [2:0]                    funct3;
  logic                          alt;
  logic [core_cfg_pkg::XLEN-1:0] imm_i;
  logic [core_cfg_pkg::XLEN-1:0] imm_u;

  assign opcode = rv_isa_pkg::opcode_e'(inst_i[6:0]);
  assign funct3 = inst_i[rv_isa_pkg::FUNCT3_LSB +: 3];
  assign alt    = inst_i[rv_isa_pkg::ALT_BIT];
  assign rd_o   = inst_i[rv_isa_pkg::RD_LSB +: core_cfg_pkg::REG_AW];

  assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_u = {inst_i[31:12], 12'b0};

  // funct3 to ALU op, alt picks SUB over ADD and SRA over SRL
  function automatic rv_isa_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic sel_alt);
    rv_isa_pkg::alu_op_e op;
    case (f3)
      3'b000:  op = sel_alt ? rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
      3'b001:  op = rv_isa_pkg::ALU_SLL;
      3'b010:  op = rv_isa_pkg::ALU_SLT;
      3'b011:  op = rv_isa_pkg::ALU_SLTU;
      3'b100:  op = rv_isa_pkg::ALU_XOR;
      3'b101:  op = sel_alt ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
      3'b110:  op = rv_isa_pkg::ALU_OR;
      default: op = rv_isa_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    op1_o     = '0;
    op2_o     = '0;
    alu_op_o  = rv_isa_pkg::ALU_ADD;
    wen_o     = 1'b1;
    use_rs1_o = 1'b0;
    use_rs2_o = 1'b0;
    illegal_o = 1'b0;
    case (opcode)
      rv_isa_pkg::OP_LUI: begin
        op2_o    = imm_u;
        alu_op_o = rv_isa_pkg::ALU_PASS2;
      end
      rv_isa_pkg::OP_AUIPC: begin
        op1_o = pc_i;
        op2_o = imm_u;
      end
      rv_isa_pkg::OP_OPIMM: begin
        op1_o     = rs1v_i;
        op2_o     = imm_i;
        use_rs1_o = 1'b1;
        // Only SRAI carries the alt bit, ADDI never subtracts
        alu_op_o  = alu_sel(funct3, alt && funct3 == 3'b101);
      end
      rv_isa_pkg::OP_OP: begin
        op1_o     = rs1v_i;
        op2_o     = rs2v_i;
        use_rs1_o = 1'b1;
        use_rs2_o = 1'b1;
        alu_op_o  = alu_sel(funct3, alt);
      end
      default: begin
        wen_o     = 1'b0; // Retires as illegal, no write
        illegal_o = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/idu_stage.sv
`default_nettype none

module idu_stage (
  input  logic                              clk,
  input  logic                              rst,
  // Fetch side
  input  logic                              inst_valid_i,
  input  logic [31:0]                       inst_i,
  input  logic [core_cfg_pkg::XLEN-1:0]     pc_i,
  output logic                              inst_ready_o,
  // Register file and scoreboard
  output logic [core_cfg_pkg::REG_AW-1:0]   rs1_o,
  output logic [core_cfg_pkg::REG_AW-1:0]   rs2_o,
  input  logic [core_cfg_pkg::XLEN-1:0]     rdata1_i,
  input  logic [core_cfg_pkg::XLEN-1:0]     rdata2_i,
  input  logic [core_cfg_pkg::NREGS-1:0]    busy_i,
  // Forwarding from execute stage two
  input  logic                              fwd_valid_i,
  input  logic [core_cfg_pkg::REG_AW-1:0]   fwd_rd_i,
  input  logic [core_cfg_pkg::XLEN-1:0]     fwd_data_i,
  // Issue port
  output logic                              iss_valid_o,
  input  logic                              iss_ready_i,
  output logic [core_cfg_pkg::XLEN-1:0]     iss_op1_o,
  output logic [core_cfg_pkg::XLEN-1:0]     iss_op2_o,
  output rv_isa_pkg::alu_op_e               iss_alu_op_o,
  output logic [core_cfg_pkg::REG_AW-1:0]   iss_rd_o,
  output logic                              iss_wen_o,
  output logic                              iss_illegal_o,
  output logic [core_cfg_pkg::XLEN-1:0]     iss_pc_o
);

  logic                          valid_q;
  logic [31:0]                   inst_q;
  logic [core_cfg_pkg::XLEN-1:0] pc_q;

  logic                          use_rs1;
  logic                          use_rs2;
  logic                          fwd1;
  logic                          fwd2;
  logic                          hazard;
  logic [core_cfg_pkg::XLEN-1:0] rs1v;
  logic [core_cfg_pkg::XLEN-1:0] rs2v;

  ////////////////////////////////////////////////////////////
  // Hazard check and operand forwarding
  ////////////////////////////////////////////////////////////
  assign rs1_o = inst_q[rv_isa_pkg::RS1_LSB +: core_cfg_pkg::REG_AW];
  assign rs2_o = inst_q[rv_isa_pkg::RS2_LSB +: core_cfg_pkg::REG_AW];

  assign fwd1 = fwd_valid_i && (fwd_rd_i == rs1_o);
  assign fwd2 = fwd_valid_i && (fwd_rd_i == rs2_o);

  assign hazard = valid_q && ((use_rs1 && busy_i[rs1_o] && !fwd1) ||
                              (use_rs2 && busy_i[rs2_o] && !fwd2));

  assign rs1v = fwd1 ? fwd_data_i : rdata1_i;
  assign rs2v = fwd2 ? fwd_data_i : rdata2_i;

  assign iss_valid_o  = valid_q && !hazard;
  assign inst_ready_o = !valid_q || (iss_valid_o && iss_ready_i); // Refill on issue
  assign iss_pc_o     = pc_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (inst_ready_o) begin
      valid_q <= inst_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (inst_ready_o && inst_valid_i) begin
      inst_q <= inst_i;
      pc_q   <= pc_i;
    end
  end

  idu_decoder u_decoder (
    .inst_i    (inst_q),
    .pc_i      (pc_q),
    .rs1v_i    (rs1v),
    .rs2v_i    (rs2v),
    .op1_o     (iss_op1_o),
    .op2_o     (iss_op2_o),
    .alu_op_o  (iss_alu_op_o),
    .rd_o      (iss_rd_o),
    .wen_o     (iss_wen_o),
    .use_rs1_o (use_rs1),
    .use_rs2_o (use_rs2),
    .illegal_o (iss_illegal_o)
  );

endmodule

`default_nettype wire

// File: verilog/exu_pipe.sv
`default_nettype none

module exu_pipe (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              iss_valid_i,
  output logic                              iss_ready_o,
  input  logic [core_cfg_pkg::XLEN-1:0]     iss_op1_i,
  input  logic [core_cfg_pkg::XLEN-1:0]     iss_op2_i,
  input  rv_isa_pkg::alu_op_e               iss_alu_op_i,
  input  logic [core_cfg_pkg::REG_AW-1:0]   iss_rd_i,
  input  logic                              iss_wen_i,
  input  logic                              iss_illegal_i,
  input  logic [core_cfg_pkg::XLEN-1:0]     iss_pc_i,
  output logic                              fwd_valid_o,
  output logic [core_cfg_pkg::REG_AW-1:0]   fwd_rd_o,
  output logic [core_cfg_pkg::XLEN-1:0]     fwd_data_o,
  output logic                              retire_valid_o,
  input  logic                              retire_ready_i,
  output logic [core_cfg_pkg::REG_AW-1:0]   retire_rd_o,
  output logic [core_cfg_pkg::XLEN-1:0]     retire_data_o,
  output logic [core_cfg_pkg::XLEN-1:0]     retire_pc_o,
  output logic                              retire_illegal_o,
  output logic                              retire_wen_o
);

  logic                          s1_valid;
  logic [core_cfg_pkg::XLEN-1:0] s1_op1;
  logic [core_cfg_pkg::XLEN-1:0] s1_op2;
  rv_isa_pkg::alu_op_e           s1_alu_op;
  logic [core_cfg_pkg::REG_AW-1:0] s1_rd;
  logic                          s1_wen;
  logic                          s1_illegal;
  logic [core_cfg_pkg::XLEN-1:0] s1_pc;
  logic                          s2_ready;
  logic [4:0]                    shamt;
  logic [core_cfg_pkg::XLEN-1:0] alu_res;

  assign s2_ready    = !retire_valid_o || retire_ready_i;
  assign iss_ready_o = !s1_valid || s2_ready;
  assign shamt       = s1_op2[4:0];

  ////////////////////////////////////////////////////////////
  // ALU on stage one operands
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (s1_alu_op)
      rv_isa_pkg::ALU_SUB:  alu_res = s1_op1 - s1_op2;
      rv_isa_pkg::ALU_SLL:  alu_res = s1_op1 << shamt;
      rv_isa_pkg::ALU_SLT:  alu_res = {31'b0, $signed(s1_op1) < $signed(s1_op2)};
      rv_isa_pkg::ALU_SLTU: alu_res = {31'b0, s1_op1 < s1_op2};
      rv_isa_pkg::ALU_XOR:  alu_res = s1_op1 ^ s1_op2;
      rv_isa_pkg::ALU_SRL:  alu_res = s1_op1 >> shamt;
      rv_isa_pkg::ALU_SRA:  alu_res = $unsigned($signed(s1_op1) >>> shamt);
      rv_isa_pkg::ALU_OR:   alu_res = s1_op1 | s1_op2;
      rv_isa_pkg::ALU_AND:  alu_res = s1_op1 & s1_op2;
      rv_isa_pkg::ALU_PASS2: alu_res = s1_op2;
      default:              alu_res = s1_op1 + s1_op2;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid       <= 1'b0;
      retire_valid_o <= 1'b0;
    end else begin
      if (iss_ready_o) s1_valid <= iss_valid_i;
      if (s2_ready) retire_valid_o <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (iss_valid_i && iss_ready_o) begin
      s1_op1     <= iss_op1_i;
      s1_op2     <= iss_op2_i;
      s1_alu_op  <= iss_alu_op_i;
      s1_rd      <= iss_rd_i;
      s1_wen     <= iss_wen_i;
      s1_illegal <= iss_illegal_i;
      s1_pc      <= iss_pc_i;
    end
    if (s1_valid && s2_ready) begin // Stage two holds under back-pressure
      retire_data_o    <= alu_res;
      retire_rd_o      <= s1_rd;
      retire_wen_o     <= s1_wen;
      retire_illegal_o <= s1_illegal;
      retire_pc_o      <= s1_pc;
    end
  end

  // A newer writer of the same register in stage one makes stage two stale
  assign fwd_valid_o = retire_valid_o && retire_wen_o && retire_rd_o != '0 &&
                       !(s1_valid && s1_wen && s1_rd == retire_rd_o);
  assign fwd_rd_o    = retire_rd_o;
  assign fwd_data_o  = retire_data_o;

endmodule

`default_nettype wire

// File: verilog/decode_exec_top.sv
`default_nettype none

module decode_exec_top (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              inst_valid_i,
  input  logic [31:0]                       inst_i,
  input  logic [core_cfg_pkg::XLEN-1:0]     pc_i,
  output logic                              inst_ready_o,
  output logic                              retire_valid_o,
  input  logic                              retire_ready_i,
  output logic [core_cfg_pkg::REG_AW-1:0]   retire_rd_o,
  output logic [core_cfg_pkg::XLEN-1:0]     retire_data_o,
  output logic [core_cfg_pkg::XLEN-1:0]     retire_pc_o,
  output logic                              retire_illegal_o
);

  logic [core_cfg_pkg::REG_AW-1:0] rs1;
  logic [core_cfg_pkg::REG_AW-1:0] rs2;
  logic [core_cfg_pkg::XLEN-1:0]   rdata1;
  logic [core_cfg_pkg::XLEN-1:0]   rdata2;
  logic [core_cfg_pkg::NREGS-1:0]  busy;
  logic                            fwd_valid;
  logic [core_cfg_pkg::REG_AW-1:0] fwd_rd;
  logic [core_cfg_pkg::XLEN-1:0]   fwd_data;
  logic                            iss_valid;
  logic                            iss_ready;
  logic [core_cfg_pkg::XLEN-1:0]   iss_op1;
  logic [core_cfg_pkg::XLEN-1:0]   iss_op2;
  rv_isa_pkg::alu_op_e             iss_alu_op;
  logic [core_cfg_pkg::REG_AW-1:0] iss_rd;
  logic                            iss_wen;
  logic                            iss_illegal;
  logic [core_cfg_pkg::XLEN-1:0]   iss_pc;
  logic                            retire_wen;
  logic                            set_busy;
  logic                            rf_we;

  assign set_busy = iss_valid && iss_ready && iss_wen;
  assign rf_we    = retire_valid_o && retire_ready_i && retire_wen; // Write back on retire

  reg_file u_reg_file (
    .clk        (clk),
    .rst        (rst),
    .raddr1_i   (rs1),
    .raddr2_i   (rs2),
    .rdata1_o   (rdata1),
    .rdata2_o   (rdata2),
    .we_i       (rf_we),
    .waddr_i    (retire_rd_o),
    .wdata_i    (retire_data_o),
    .set_busy_i (set_busy),
    .set_addr_i (iss_rd),
    .busy_o     (busy)
  );

  idu_stage u_idu (
    .clk (clk), .rst (rst),
    .inst_valid_i (inst_valid_i), .inst_i (inst_i), .pc_i (pc_i),
    .inst_ready_o (inst_ready_o),
    .rs1_o (rs1), .rs2_o (rs2), .rdata1_i (rdata1), .rdata2_i (rdata2),
    .busy_i (busy),
    .fwd_valid_i (fwd_valid), .fwd_rd_i (fwd_rd), .fwd_data_i (fwd_data),
    .iss_valid_o (iss_valid), .iss_ready_i (iss_ready),
    .iss_op1_o (iss_op1), .iss_op2_o (iss_op2), .iss_alu_op_o (iss_alu_op),
    .iss_rd_o (iss_rd), .iss_wen_o (iss_wen), .iss_illegal_o (iss_illegal),
    .iss_pc_o (iss_pc)
  );

  exu_pipe u_exu (
    .clk (clk), .rst (rst),
    .iss_valid_i (iss_valid), .iss_ready_o (iss_ready),
    .iss_op1_i (iss_op1), .iss_op2_i (iss_op2), .iss_alu_op_i (iss_alu_op),
    .iss_rd_i (iss_rd), .iss_wen_i (iss_wen), .iss_illegal_i (iss_illegal),
    .iss_pc_i (iss_pc),
    .fwd_valid_o (fwd_valid), .fwd_rd_o (fwd_rd), .fwd_data_o (fwd_data),
    .retire_valid_o (retire_valid_o), .retire_ready_i (retire_ready_i),
    .retire_rd_o (retire_rd_o), .retire_data_o (retire_data_o),
    .retire_pc_o (retire_pc_o), .retire_illegal_o (retire_illegal_o),
    .retire_wen_o (retire_wen)
  );

endmodule

`default_nettype wire

// File: dv/decode_exec_asserts.sv
`default_nettype none

module decode_exec_asserts (
  input logic                              clk,
  input logic                              rst,
  input logic                              inst_ready_i,
  input logic                              retire_valid_i,
  input logic                              retire_ready_i,
  input logic [core_cfg_pkg::REG_AW-1:0]   retire_rd_i,
  input logic [core_cfg_pkg::XLEN-1:0]     retire_data_i,
  input logic [core_cfg_pkg::XLEN-1:0]     retire_pc_i,
  input logic                              retire_illegal_i
);

  int   err_cnt = 0;
  logic stalled;

  assign stalled = retire_valid_i && !retire_ready_i; // Retire held off by the outside

  ////////////////////////////////////////////////////////////
  // Retire port under back-pressure
  ////////////////////////////////////////////////////////////
  a_hold_valid: assert property (@(posedge clk) disable iff (rst) stalled |=> retire_valid_i)
    else begin
      $error("Retire valid dropped while the retire was stalled");
      err_cnt++;
    end

  a_hold_data: assert property (@(posedge clk) disable iff (rst)
    stalled |=> $stable({retire_rd_i, retire_data_i, retire_pc_i, retire_illegal_i}))
    else begin
      $error("Retire outputs changed while the retire was stalled");
      err_cnt++;
    end

  // State right after reset
  a_reset_state: assert property (@(posedge clk) $fell(rst) |-> !retire_valid_i && inst_ready_i)
    else begin
      $error("Retire valid high or instruction ready low after reset");
      err_cnt++;
    end

endmodule

`default_nettype wire

// File: dv/tb_decode_exec.sv
`default_nettype none

module tb_decode_exec;

  localparam int NUM_INSTS  = 300;
  localparam int MAX_CYCLES = NUM_INSTS * 8;

  logic                              clk;
  logic                              rst;
  logic                              inst_valid_i;
  logic [31:0]                       inst_i;
  logic [core_cfg_pkg::XLEN-1:0]     pc_i;
  logic                              inst_ready_o;
  logic                              retire_valid_o;
  logic                              retire_ready_i;
  logic [core_cfg_pkg::REG_AW-1:0]   retire_rd_o;
  logic [core_cfg_pkg::XLEN-1:0]     retire_data_o;
  logic [core_cfg_pkg::XLEN-1:0]     retire_pc_o;
  logic                              retire_illegal_o;

  // Mirror registers and expected retires in program order
  logic [core_cfg_pkg::XLEN-1:0]   mirror [core_cfg_pkg::NREGS];
  logic [core_cfg_pkg::REG_AW-1:0] exp_rd [NUM_INSTS+1];
  logic [core_cfg_pkg::XLEN-1:0]   exp_data [NUM_INSTS+1];
  logic [core_cfg_pkg::XLEN-1:0]   exp_pc [NUM_INSTS+1];
  logic                            exp_illegal [NUM_INSTS+1];
  int                              wr_ptr = 0;
  int                              rd_ptr = 0;
  int                              cycles = 0;
  logic [31:0]                     lfsr = 32'h158;
  logic                            retiring;

  decode_exec_top u_dut (
    .clk (clk), .rst (rst),
    .inst_valid_i (inst_valid_i), .inst_i (inst_i), .pc_i (pc_i),
    .inst_ready_o (inst_ready_o),
    .retire_valid_o (retire_valid_o), .retire_ready_i (retire_ready_i),
    .retire_rd_o (retire_rd_o), .retire_data_o (retire_data_o),
    .retire_pc_o (retire_pc_o), .retire_illegal_o (retire_illegal_o)
  );

  bind decode_exec_top decode_exec_asserts u_asserts (
    .clk (clk), .rst (rst), .inst_ready_i (inst_ready_o),
    .retire_valid_i (retire_valid_o), .retire_ready_i (retire_ready_i),
    .retire_rd_i (retire_rd_o), .retire_data_i (retire_data_o),
    .retire_pc_i (retire_pc_o), .retire_illegal_i (retire_illegal_o)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  task automatic stop_with_error(input string what);
    $display("%s", what);
    $display("Verification failed");
    $fatal(1);
  endtask

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      val  = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic logic [4:0] pick_reg();
    logic [3:0] r;
    r = 4'(rand_bits(4));
    if (r[3] && rand_bits(1) == 0) r[3] = 1'b0; // Favor x0..x7 so chains form
    return {1'b0, r};
  endfunction

  function automatic logic [31:0] random_inst();
    logic [2:0]  kind;
    logic [2:0]  f3;
    logic        alt;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    logic [19:0] upper;
    kind  = 3'(rand_bits(3));
    f3    = 3'(rand_bits(3));
    alt   = rand_bits(1) != 0 && (f3 == 3'b000 || f3 == 3'b101);
    rd    = pick_reg();
    rs1   = pick_reg();
    rs2   = pick_reg();
    imm   = 12'(rand_bits(12));
    upper = 20'(rand_bits(20));
    if (f3 == 3'b001 || f3 == 3'b101) imm[11:5] = {1'b0, alt, 5'b0}; // Shift-immediate form
    case (kind)
      3'd0, 3'd1, 3'd2: return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, rv_isa_pkg::OP_OP};
      3'd3, 3'd4:       return {imm, rs1, f3, rd, rv_isa_pkg::OP_OPIMM};
      3'd5:             return {upper, rd, rv_isa_pkg::OP_LUI};
      3'd6:             return {upper, rd, rv_isa_pkg::OP_AUIPC};
      default:          return {upper, rd, 7'b0000011}; // Unsupported load opcode
    endcase
  endfunction

  // RV32 semantics on the mirror registers
  function automatic logic [31:0] ref_result(input logic [31:0] inst, input logic [31:0] pc);
    logic [31:0] a;
    logic [31:0] b;
    a = mirror[inst[18:15]];
    case (inst[6:0])
      rv_isa_pkg::OP_LUI:   return {inst[31:12], 12'h000};
      rv_isa_pkg::OP_AUIPC: return pc + {inst[31:12], 12'h000};
      rv_isa_pkg::OP_OP:    b = mirror[inst[23:20]];
      default:              b = {{20{inst[31]}}, inst[31:20]};
    endcase
    case (inst[14:12])
      3'b000: return (inst[6:0] == rv_isa_pkg::OP_OP && inst[30]) ? a - b : a + b;
      3'b001: return a << b[4:0];
      3'b010: return {31'b0, $signed(a) < $signed(b)};
      3'b011: return {31'b0, a < b};
      3'b100: return a ^ b;
      3'b101: begin
        if (inst[30]) return $signed(a) >>> b[4:0];
        return a >> b[4:0];
      end
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic model_accept(input logic [31:0] inst, input logic [31:0] pc);
    logic legal;
    legal = inst[6:0] inside {rv_isa_pkg::OP_LUI, rv_isa_pkg::OP_AUIPC,
                              rv_isa_pkg::OP_OP, rv_isa_pkg::OP_OPIMM};
    exp_rd[wr_ptr]      = inst[10:7];
    exp_data[wr_ptr]    = ref_result(inst, pc);
    exp_pc[wr_ptr]      = pc;
    exp_illegal[wr_ptr] = !legal;
    if (legal && inst[10:7] != 0) mirror[inst[10:7]] = exp_data[wr_ptr];
    wr_ptr++;
  endtask

  always @(posedge clk) begin
    if (!rst && inst_valid_i && inst_ready_o) model_accept(inst_i, pc_i);
    if (!rst && retiring) rd_ptr++;
    cycles++;
    if (cycles == MAX_CYCLES) stop_with_error("Timeout: not every instruction retired in time");
    if (u_dut.u_asserts.err_cnt != 0) stop_with_error("A bound protocol assertion failed");
  end

  ////////////////////////////////////////////////////////////
  // Retire checks against the expected queue head
  ////////////////////////////////////////////////////////////
  assign retiring = retire_valid_o && retire_ready_i;

  a_no_extra: assert property (@(posedge clk) disable iff (rst) retiring |-> rd_ptr < wr_ptr)
    else stop_with_error("Retire seen with no accepted instruction outstanding");

  a_pc: assert property (@(posedge clk) disable iff (rst)
    retiring && rd_ptr < wr_ptr |-> retire_pc_o == exp_pc[rd_ptr])
    else stop_with_error($sformatf("ERR retire_pc_o got %h expected %h",
                                   $sampled(retire_pc_o), exp_pc[$sampled(rd_ptr)]));

  a_illegal: assert property (@(posedge clk) disable iff (rst)
    retiring && rd_ptr < wr_ptr |-> retire_illegal_o == exp_illegal[rd_ptr])
    else stop_with_error($sformatf("ERR retire_illegal_o got %h expected %h",
                                   $sampled(retire_illegal_o), exp_illegal[$sampled(rd_ptr)]));

  a_rd: assert property (@(posedge clk) disable iff (rst)
    retiring && rd_ptr < wr_ptr && !exp_illegal[rd_ptr] |-> retire_rd_o == exp_rd[rd_ptr])
    else stop_with_error($sformatf("ERR retire_rd_o got %h expected %h",
                                   $sampled(retire_rd_o), exp_rd[$sampled(rd_ptr)]));

  a_data: assert property (@(posedge clk) disable iff (rst)
    retiring && rd_ptr < wr_ptr && !exp_illegal[rd_ptr] |-> retire_data_o == exp_data[rd_ptr])
    else stop_with_error($sformatf("ERR retire_data_o got %h expected %h",
                                   $sampled(retire_data_o), exp_data[$sampled(rd_ptr)]));

  initial begin
    logic [31:0] pc_next;
    logic [19:0] upper;
    logic        took;
    int          sent;
    foreach (mirror[i]) mirror[i] = '0;
    rst            = 1'b1;
    inst_valid_i   = 1'b0;
    inst_i         = '0;
    pc_i           = '0;
    retire_ready_i = 1'b0;
    pc_next        = 32'h0000_1000;
    sent           = 0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    while (sent < NUM_INSTS) begin
      if (!inst_valid_i) begin
        inst_valid_i = rand_bits(3) != 0;
        if (inst_valid_i) begin
          upper = 20'(rand_bits(20));
          // LUI to x1..x15 first so no register is read before its first write
          inst_i = (sent < 15) ? {upper, 1'b0, 4'(sent + 1), rv_isa_pkg::OP_LUI} : random_inst();
          pc_i   = pc_next;
        end
      end
      retire_ready_i = rand_bits(2) != 0;
      @(posedge clk);
      took = inst_valid_i && inst_ready_o;
      #1;
      if (took) begin
        sent++;
        pc_next      = pc_next + 4;
        inst_valid_i = 1'b0;
      end
    end
    retire_ready_i = 1'b1;
    while (rd_ptr != NUM_INSTS) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    if (rd_ptr == wr_ptr && u_dut.u_asserts.err_cnt == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      stop_with_error("Retire count does not match the accepted instructions");
    end
  end

endmodule

`default_nettype wire

// File: sources.f
verilog/core_cfg_pkg.sv
verilog/rv_isa_pkg.sv
verilog/reg_file.sv
verilog/idu_decoder.sv
verilog/idu_stage.sv
verilog/exu_pipe.sv
verilog/decode_exec_top.sv
dv/decode_exec_asserts.sv
dv/tb_decode_exec.sv

// File: Bender.yml
package:
  name: decode_exec

sources:
  - files:
      - verilog/core_cfg_pkg.sv
      - verilog/rv_isa_pkg.sv
      - verilog/reg_file.sv
      - verilog/idu_decoder.sv
      - verilog/idu_stage.sv
      - verilog/exu_pipe.sv
      - verilog/decode_exec_top.sv
  - target: test
    files:
      - dv/decode_exec_asserts.sv
      - dv/tb_decode_exec.sv
